/* hw/acq_macros.svh */
`ifndef ACQ_MACROS_SVH
`define ACQ_MACROS_SVH

// sample and channel geometry
`define ACQ_SAMPLE_W 16
`define ACQ_RHD_CHANNELS 7
`define ACQ_RHS_CHANNELS 5
`define ACQ_CHAN_W 4

// samples gathered per channel during an impedance check
`define ACQ_ZCHECK_SAMPLES 8

// engine timing in clk cycles
`define ACQ_SAMPLE_CYCLES 4
`define ACQ_CONFIG_CYCLES 8

// loopback source seeds, one per chip group
`define ACQ_RHD_SEED 16'h0040
`define ACQ_RHS_SEED 16'h0080

`endif

/* hw/acq_pkg.sv */
`default_nettype none

`include "acq_macros.svh"

package acq_pkg;

    typedef logic [`ACQ_SAMPLE_W-1:0] sample_t;

    typedef enum logic [1:0] {
        OP_CONFIG,
        OP_RECORD,
        OP_ZCHECK
    } acq_op_e;

    typedef enum logic {
        GROUP_RHD,
        GROUP_RHS
    } chip_group_e;

    typedef struct packed {
        logic start;
        acq_op_e op;
        logic [`ACQ_CHAN_W-1:0] channel;
    } acq_cmd_t;

    typedef struct packed {
        logic busy;
        logic done;
    } engine_status_t;

    // element 0 of each array is channel 0 or the first sample
    typedef sample_t [`ACQ_RHD_CHANNELS-1:0] rhd_frame_t;
    typedef sample_t [`ACQ_RHS_CHANNELS-1:0] rhs_frame_t;
    typedef sample_t [`ACQ_ZCHECK_SAMPLES-1:0] zcheck_block_t;

    typedef struct packed {
        rhs_frame_t rhs;
        rhd_frame_t rhd;
    } record_frame_t;

    typedef struct packed {
        chip_group_e group;
        logic [`ACQ_CHAN_W-1:0] channel;
        zcheck_block_t block;
    } zcheck_result_t;

endpackage

`default_nettype wire

/* hw/zcheck_channel_counter.sv */
`default_nettype none

`include "acq_macros.svh"

module zcheck_channel_counter import acq_pkg::*; (
    input wire clk,
    input wire config_done_reset_flag,
    input wire clear,
    input wire advance,
    output chip_group_e group,
    output logic [`ACQ_CHAN_W-1:0] channel,
    output logic sweep_end
);

    localparam logic [`ACQ_CHAN_W-1:0] RHD_LAST = `ACQ_CHAN_W'(`ACQ_RHD_CHANNELS - 1);
    localparam logic [`ACQ_CHAN_W-1:0] RHS_LAST = `ACQ_CHAN_W'(`ACQ_RHS_CHANNELS - 1);

    always_ff @(posedge clk) begin
        if (config_done_reset_flag || clear) begin
            group <= GROUP_RHD;
            channel <= '0;
            sweep_end <= 1'b0;
        end else if (advance && !sweep_end) begin
            if (group == GROUP_RHD) begin
                if (channel == RHD_LAST) begin
                    group <= GROUP_RHS; // rhs channels follow the last rhd one
                    channel <= '0;
                end else begin
                    channel <= channel + 1'b1;
                end
            end else if (channel == RHS_LAST) begin
                sweep_end <= 1'b1; // channel parks on the last rhs channel
            end else begin
                channel <= channel + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        channel < ((group == GROUP_RHD) ? `ACQ_RHD_CHANNELS : `ACQ_RHS_CHANNELS));

endmodule

`default_nettype wire

/* hw/chip_engine.sv */
`default_nettype none

`include "acq_macros.svh"

module chip_engine import acq_pkg::*; #(
    parameter type frame_t = rhd_frame_t
) (
    input wire clk,
    input wire config_done_reset_flag,
    input wire acq_cmd_t cmd,
    input wire sample_t sample,
    output engine_status_t status,
    output logic next,
    output frame_t frame,
    output zcheck_block_t block
);

    localparam int SW = `ACQ_SAMPLE_W;
    localparam int S = `ACQ_SAMPLE_CYCLES;
    localparam int CHANNELS = $bits(frame_t) / SW;
    localparam int RECORD_CYCLES = CHANNELS * S;
    localparam int ZCHECK_CYCLES = `ACQ_ZCHECK_SAMPLES * S;
    localparam int OP_MAX = (RECORD_CYCLES > ZCHECK_CYCLES) ? RECORD_CYCLES : ZCHECK_CYCLES;
    localparam int MAX_CYCLES = (OP_MAX > `ACQ_CONFIG_CYCLES) ? OP_MAX : `ACQ_CONFIG_CYCLES;
    localparam int TIMER_W = $clog2(MAX_CYCLES);
    localparam int PHASE_W = $clog2(S);
    localparam int MAX_SAMPLES = (CHANNELS > `ACQ_ZCHECK_SAMPLES) ? CHANNELS : `ACQ_ZCHECK_SAMPLES;
    localparam int IDX_W = $clog2(MAX_SAMPLES);

    acq_op_e op;
    logic [TIMER_W-1:0] timer; // busy cycles left including the current one
    logic [PHASE_W-1:0] phase;
    logic [IDX_W-1:0] idx;
    logic [$bits(frame_t)-1:0] frame_q;

    // sampling falls on the last cycle of each sample period, so the final
    // sample lands just before done
    assign next = status.busy && (op != OP_CONFIG) && (phase == PHASE_W'(S - 1));
    assign frame = frame_t'(frame_q);

    always_ff @(posedge clk) begin
        if (config_done_reset_flag) begin
            status <= '0;
            op <= OP_CONFIG;
            timer <= '0;
            phase <= '0;
            idx <= '0;
        end else begin
            status.done <= 1'b0;
            if (cmd.start) begin
                status.busy <= 1'b1;
                op <= cmd.op;
                phase <= PHASE_W'(1);
                idx <= '0;
                case (cmd.op)
                    OP_RECORD: timer <= TIMER_W'(RECORD_CYCLES - 1);
                    OP_ZCHECK: timer <= TIMER_W'(ZCHECK_CYCLES - 1);
                    default: timer <= TIMER_W'(`ACQ_CONFIG_CYCLES - 1);
                endcase
            end else if (status.busy) begin
                phase <= next ? '0 : phase + 1'b1;
                if (next) idx <= idx + 1'b1;
                timer <= timer - 1'b1;
                if (timer == TIMER_W'(1)) begin
                    status.busy <= 1'b0;
                    status.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (next) begin
            if (op == OP_RECORD) frame_q[idx*SW +: SW] <= sample;
            else block[idx] <= sample;
        end
    end

    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        status.done |-> !status.busy);

    // the sequencer only sends channels that this group actually has
    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        cmd.start && cmd.op == OP_ZCHECK |-> cmd.channel < CHANNELS);

endmodule

`default_nettype wire

/* hw/loopback_source.sv */
`default_nettype none

`include "acq_macros.svh"

module loopback_source import acq_pkg::*; #(
    parameter sample_t SEED = `ACQ_RHD_SEED
) (
    input wire clk,
    input wire config_done_reset_flag,
    input wire next,
    output sample_t sample
);

    logic feedback;

    // fibonacci taps 16 14 13 11 in one-based numbering
    assign feedback = sample[15] ^ sample[13] ^ sample[12] ^ sample[10];

    always_ff @(posedge clk) begin
        if (config_done_reset_flag) begin
            sample <= SEED;
        end else if (next) begin
            sample <= {sample[14:0], feedback}; // current value was taken this cycle
        end
    end

    // a zero state would lock the register up for good
    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        sample != '0);

endmodule

`default_nettype wire

/* hw/acq_sequencer.sv */
`default_nettype none

`include "acq_macros.svh"

module acq_sequencer import acq_pkg::*; (
    input wire clk,
    input wire config_done_reset_flag,
    input wire record_start,
    input wire record_stop,
    input wire zcheck_start,
    input wire engine_status_t rhd_status,
    input wire engine_status_t rhs_status,
    input wire rhd_frame_t rhd_frame,
    input wire rhs_frame_t rhs_frame,
    input wire zcheck_block_t rhd_block,
    input wire zcheck_block_t rhs_block,
    input wire chip_group_e zc_group,
    input wire [`ACQ_CHAN_W-1:0] zc_channel,
    input wire sweep_end,
    output acq_cmd_t rhd_cmd,
    output acq_cmd_t rhs_cmd,
    output logic zc_clear,
    output logic zc_advance,
    output logic busy,
    output logic zcheck_done,
    output logic data_out_record_valid,
    output logic data_out_zcheck_valid,
    output record_frame_t data_out_record,
    output zcheck_result_t data_out_zcheck
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CONFIG,
        S_RECORD,
        S_ZCHECK,
        S_DONE
    } state_e;

    state_e state;
    acq_op_e follow_op; // where a finished config pass leads, OP_CONFIG means back to idle
    acq_op_e cmd_op;
    logic rhd_start;
    logic rhs_start;
    logic rhd_got;
    logic rhs_got;
    logic stop_pending;
    logic issue; // next zcheck channel is launched once the counter has moved
    logic rhd_fin;
    logic rhs_fin;
    zcheck_block_t zc_block;

    assign rhd_cmd = '{start: rhd_start, op: cmd_op, channel: zc_channel};
    assign rhs_cmd = '{start: rhs_start, op: cmd_op, channel: zc_channel};

    assign rhd_fin = rhd_got || rhd_status.done;
    assign rhs_fin = rhs_got || rhs_status.done;
    assign zc_block = (zc_group == GROUP_RHD) ? rhd_block : rhs_block;

    assign busy = (state != S_IDLE);
    assign zc_clear = (state == S_IDLE) && zcheck_start && !record_start;
    assign zc_advance = (state == S_ZCHECK) &&
                        ((zc_group == GROUP_RHD) ? rhd_status.done : rhs_status.done);

    always_ff @(posedge clk) begin
        rhd_start <= 1'b0;
        rhs_start <= 1'b0;
        data_out_record_valid <= 1'b0;
        data_out_zcheck_valid <= 1'b0;
        zcheck_done <= 1'b0;
        if (config_done_reset_flag) begin
            state <= S_IDLE;
            follow_op <= OP_CONFIG;
            cmd_op <= OP_CONFIG;
            rhd_got <= 1'b0;
            rhs_got <= 1'b0;
            stop_pending <= 1'b0;
            issue <= 1'b0;
        end else begin
            if (record_stop && state != S_IDLE) stop_pending <= 1'b1; // acted on between frames
            case (state)
                S_IDLE: begin
                    if (record_start || zcheck_start) begin
                        follow_op <= record_start ? OP_RECORD : OP_ZCHECK;
                        stop_pending <= 1'b0;
                        cmd_op <= OP_CONFIG;
                        rhd_start <= 1'b1;
                        rhs_start <= 1'b1;
                        state <= S_CONFIG;
                    end
                end
                S_CONFIG: begin
                    if (rhd_fin && rhs_fin) begin
                        rhd_got <= 1'b0;
                        rhs_got <= 1'b0;
                        case (follow_op)
                            OP_RECORD: begin
                                if (stop_pending || record_stop) begin
                                    state <= S_DONE;
                                end else begin
                                    cmd_op <= OP_RECORD;
                                    rhd_start <= 1'b1;
                                    rhs_start <= 1'b1;
                                    state <= S_RECORD;
                                end
                            end
                            OP_ZCHECK: begin
                                issue <= 1'b1;
                                state <= S_ZCHECK;
                            end
                            default: state <= S_IDLE;
                        endcase
                    end else begin
                        rhd_got <= rhd_fin;
                        rhs_got <= rhs_fin;
                    end
                end
                S_RECORD: begin
                    if (rhd_status.done) data_out_record.rhd <= rhd_frame;
                    if (rhs_status.done) data_out_record.rhs <= rhs_frame;
                    if (rhd_fin && rhs_fin) begin
                        rhd_got <= 1'b0;
                        rhs_got <= 1'b0;
                        data_out_record_valid <= 1'b1;
                        if (stop_pending || record_stop) begin
                            state <= S_DONE;
                        end else begin
                            rhd_start <= 1'b1;
                            rhs_start <= 1'b1;
                        end
                    end else begin
                        rhd_got <= rhd_fin;
                        rhs_got <= rhs_fin;
                    end
                end
                S_ZCHECK: begin
                    if (issue) begin
                        issue <= 1'b0;
                        if (sweep_end) begin
                            zcheck_done <= 1'b1;
                            state <= S_DONE;
                        end else begin
                            cmd_op <= OP_ZCHECK;
                            rhd_start <= (zc_group == GROUP_RHD);
                            rhs_start <= (zc_group == GROUP_RHS);
                        end
                    end else if (zc_advance) begin
                        // tag with the channel before the counter moves on
                        data_out_zcheck <= '{group: zc_group, channel: zc_channel, block: zc_block};
                        data_out_zcheck_valid <= 1'b1;
                        issue <= 1'b1;
                    end
                end
                default: begin
                    // closing config pass before going idle
                    follow_op <= OP_CONFIG;
                    cmd_op <= OP_CONFIG;
                    rhd_start <= 1'b1;
                    rhs_start <= 1'b1;
                    state <= S_CONFIG;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        !(data_out_record_valid && data_out_zcheck_valid));

    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        rhd_cmd.start |-> !rhd_status.busy);

    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        rhs_cmd.start |-> !rhs_status.busy);

endmodule

`default_nettype wire

/* hw/acq_top.sv */
`default_nettype none

`include "acq_macros.svh"

module acq_top import acq_pkg::*; (
    input wire clk,
    input wire config_done_reset_flag,
    input wire record_start,
    input wire record_stop,
    input wire zcheck_start,
    output logic busy,
    output logic zcheck_done,
    output logic data_out_record_valid,
    output logic data_out_zcheck_valid,
    output record_frame_t data_out_record,
    output zcheck_result_t data_out_zcheck
);

    acq_cmd_t rhd_cmd;
    acq_cmd_t rhs_cmd;
    engine_status_t rhd_status;
    engine_status_t rhs_status;
    rhd_frame_t rhd_frame;
    rhs_frame_t rhs_frame;
    zcheck_block_t rhd_block;
    zcheck_block_t rhs_block;
    sample_t rhd_sample;
    sample_t rhs_sample;
    logic rhd_next;
    logic rhs_next;
    chip_group_e zc_group;
    logic [`ACQ_CHAN_W-1:0] zc_channel;
    logic zc_clear;
    logic zc_advance;
    logic sweep_end;

    acq_sequencer u_sequencer (
        .clk(clk),
        .config_done_reset_flag(config_done_reset_flag),
        .record_start(record_start),
        .record_stop(record_stop),
        .zcheck_start(zcheck_start),
        .rhd_status(rhd_status),
        .rhs_status(rhs_status),
        .rhd_frame(rhd_frame),
        .rhs_frame(rhs_frame),
        .rhd_block(rhd_block),
        .rhs_block(rhs_block),
        .zc_group(zc_group),
        .zc_channel(zc_channel),
        .sweep_end(sweep_end),
        .rhd_cmd(rhd_cmd),
        .rhs_cmd(rhs_cmd),
        .zc_clear(zc_clear),
        .zc_advance(zc_advance),
        .busy(busy),
        .zcheck_done(zcheck_done),
        .data_out_record_valid(data_out_record_valid),
        .data_out_zcheck_valid(data_out_zcheck_valid),
        .data_out_record(data_out_record),
        .data_out_zcheck(data_out_zcheck)
    );

    zcheck_channel_counter u_zc_counter (
        .clk(clk),
        .config_done_reset_flag(config_done_reset_flag),
        .clear(zc_clear),
        .advance(zc_advance),
        .group(zc_group),
        .channel(zc_channel),
        .sweep_end(sweep_end)
    );

    chip_engine #(.frame_t(rhd_frame_t)) u_rhd_engine (
        .clk(clk),
        .config_done_reset_flag(config_done_reset_flag),
        .cmd(rhd_cmd),
        .sample(rhd_sample),
        .status(rhd_status),
        .next(rhd_next),
        .frame(rhd_frame),
        .block(rhd_block)
    );

    chip_engine #(.frame_t(rhs_frame_t)) u_rhs_engine (
        .clk(clk),
        .config_done_reset_flag(config_done_reset_flag),
        .cmd(rhs_cmd),
        .sample(rhs_sample),
        .status(rhs_status),
        .next(rhs_next),
        .frame(rhs_frame),
        .block(rhs_block)
    );

    loopback_source #(.SEED(`ACQ_RHD_SEED)) u_rhd_source (
        .clk(clk),
        .config_done_reset_flag(config_done_reset_flag),
        .next(rhd_next),
        .sample(rhd_sample)
    );

    loopback_source #(.SEED(`ACQ_RHS_SEED)) u_rhs_source (
        .clk(clk),
        .config_done_reset_flag(config_done_reset_flag),
        .next(rhs_next),
        .sample(rhs_sample)
    );

endmodule

`default_nettype wire

/* testbench/acq_checker.sv */
`default_nettype none

`include "acq_macros.svh"

module acq_checker import acq_pkg::*; (
    input wire clk,
    input wire config_done_reset_flag,
    input wire busy,
    input wire zcheck_done,
    input wire data_out_record_valid,
    input wire data_out_zcheck_valid,
    input wire record_frame_t data_out_record,
    input wire zcheck_result_t data_out_zcheck,
    output int record_count,
    output int zcheck_count,
    output int zcheck_done_count,
    output int error_count
);

    localparam int ZC_TOTAL = `ACQ_RHD_CHANNELS + `ACQ_RHS_CHANNELS;

    string current_test = "none";
    sample_t rhd_model; // value each source should present next
    sample_t rhs_model;
    int zc_index;

    // fibonacci step with taps 15 13 12 10, shifting left into bit 0
    function automatic sample_t lfsr_next(input sample_t state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    task set_test(input string name);
        current_test = name;
    endtask

    always @(posedge clk) begin : compare
        int errs;
        rhd_frame_t exp_rhd;
        rhs_frame_t exp_rhs;
        zcheck_block_t exp_block;
        chip_group_e exp_group;
        logic [`ACQ_CHAN_W-1:0] exp_channel;
        errs = 0;
        if (config_done_reset_flag) begin
            rhd_model = `ACQ_RHD_SEED;
            rhs_model = `ACQ_RHS_SEED;
            zc_index = 0;
            record_count <= 0;
            zcheck_count <= 0;
            zcheck_done_count <= 0;
            error_count <= 0;
        end else begin
            if (data_out_record_valid) begin
                for (int i = 0; i < `ACQ_RHD_CHANNELS; i++) begin
                    exp_rhd[i] = rhd_model;
                    rhd_model = lfsr_next(rhd_model);
                end
                for (int i = 0; i < `ACQ_RHS_CHANNELS; i++) begin
                    exp_rhs[i] = rhs_model;
                    rhs_model = lfsr_next(rhs_model);
                end
                if (data_out_record.rhd !== exp_rhd) begin
                    $display("error %s: rhd frame expected %h actual %h",
                             current_test, exp_rhd, data_out_record.rhd);
                    errs++;
                end
                if (data_out_record.rhs !== exp_rhs) begin
                    $display("error %s: rhs frame expected %h actual %h",
                             current_test, exp_rhs, data_out_record.rhs);
                    errs++;
                end
                record_count <= record_count + 1;
            end
            if (data_out_zcheck_valid) begin
                exp_group = (zc_index < `ACQ_RHD_CHANNELS) ? GROUP_RHD : GROUP_RHS;
                exp_channel = `ACQ_CHAN_W'((zc_index < `ACQ_RHD_CHANNELS) ?
                                           zc_index : zc_index - `ACQ_RHD_CHANNELS);
                for (int j = 0; j < `ACQ_ZCHECK_SAMPLES; j++) begin
                    if (exp_group == GROUP_RHD) begin
                        exp_block[j] = rhd_model;
                        rhd_model = lfsr_next(rhd_model);
                    end else begin
                        exp_block[j] = rhs_model;
                        rhs_model = lfsr_next(rhs_model);
                    end
                end
                if (data_out_zcheck.group !== exp_group ||
                    data_out_zcheck.channel !== exp_channel) begin
                    $display("error %s: zcheck group/channel expected %0d/%0d actual %0d/%0d",
                             current_test, exp_group, exp_channel,
                             data_out_zcheck.group, data_out_zcheck.channel);
                    errs++;
                end
                if (data_out_zcheck.block !== exp_block) begin
                    $display("error %s: zcheck block expected %h actual %h",
                             current_test, exp_block, data_out_zcheck.block);
                    errs++;
                end
                zc_index++;
                zcheck_count <= zcheck_count + 1;
            end
            if (zcheck_done) begin
                if (zc_index != ZC_TOTAL) begin
                    $display("error %s: results before zcheck_done expected %0d actual %0d",
                             current_test, ZC_TOTAL, zc_index);
                    errs++;
                end
                if (!busy) begin
                    $display("%s: zcheck_done pulsed while busy was already low", current_test);
                    errs++;
                end
                zc_index = 0; // next sweep starts over at rhd channel 0
                zcheck_done_count <= zcheck_done_count + 1;
            end
            error_count <= error_count + errs;
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_acq_top.sv */
`default_nettype none

`include "acq_macros.svh"

module tb_acq_top import acq_pkg::*; ();

    logic clk;
    logic config_done_reset_flag;
    logic record_start;
    logic record_stop;
    logic zcheck_start;
    logic busy;
    logic zcheck_done;
    logic data_out_record_valid;
    logic data_out_zcheck_valid;
    record_frame_t data_out_record;
    zcheck_result_t data_out_zcheck;

    int record_count;
    int zcheck_count;
    int zcheck_done_count;
    int checker_errors;

    int seed;
    int local_errors;
    int start_errors;
    int tests_run;
    int tests_failed;
    int frames;
    string test_name;

    acq_top dut0 (
        .clk(clk),
        .config_done_reset_flag(config_done_reset_flag),
        .record_start(record_start),
        .record_stop(record_stop),
        .zcheck_start(zcheck_start),
        .busy(busy),
        .zcheck_done(zcheck_done),
        .data_out_record_valid(data_out_record_valid),
        .data_out_zcheck_valid(data_out_zcheck_valid),
        .data_out_record(data_out_record),
        .data_out_zcheck(data_out_zcheck)
    );

    acq_checker checker0 (
        .clk(clk),
        .config_done_reset_flag(config_done_reset_flag),
        .busy(busy),
        .zcheck_done(zcheck_done),
        .data_out_record_valid(data_out_record_valid),
        .data_out_zcheck_valid(data_out_zcheck_valid),
        .data_out_record(data_out_record),
        .data_out_zcheck(data_out_zcheck),
        .record_count(record_count),
        .zcheck_count(zcheck_count),
        .zcheck_done_count(zcheck_done_count),
        .error_count(checker_errors)
    );

    always #20 clk = ~clk;

    task automatic begin_test(input string name);
        test_name = name;
        checker0.set_test(name);
        start_errors = checker_errors + local_errors;
    endtask

    task automatic end_test();
        int fails;
        repeat (2) @(posedge clk); // let the last comparisons land in the count
        fails = checker_errors + local_errors - start_errors;
        tests_run++;
        if (fails == 0) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, fails);
        end
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int i;
        i = 0;
        while (busy !== level && i < limit) begin
            @(posedge clk);
            i++;
        end
        if (busy !== level) begin
            $display("%s: busy did not go to %0b in time", test_name, level);
            local_errors++;
        end
    endtask

    task automatic wait_records(input int target, input int limit);
        int i;
        i = 0;
        while (record_count < target && i < limit) begin
            @(posedge clk);
            i++;
        end
        if (record_count < target) begin
            $display("%s: timed out waiting for record frame %0d", test_name, target);
            local_errors++;
        end
    endtask

    task automatic wait_zchecks(input int target, input int limit);
        int i;
        i = 0;
        while (zcheck_count < target && i < limit) begin
            @(posedge clk);
            i++;
        end
        if (zcheck_count < target) begin
            $display("%s: timed out waiting for zcheck result %0d", test_name, target);
            local_errors++;
        end
    endtask

    // a record session of n frames, optionally with a stray zcheck_start inside it
    task automatic run_record(input int n, input bit stray_start);
        int base;
        int zbase;
        int at_stop;
        base = record_count;
        zbase = zcheck_count;
        record_start <= 1'b1;
        @(posedge clk);
        record_start <= 1'b0;
        wait_busy(1'b1, 2);
        wait_records(base + 1, 200);
        if (stray_start) begin
            zcheck_start <= 1'b1;
            @(posedge clk);
            zcheck_start <= 1'b0;
        end
        wait_records(base + n, 200 * n);
        at_stop = record_count;
        record_stop <= 1'b1;
        @(posedge clk);
        record_stop <= 1'b0;
        wait_busy(1'b0, 300);
        repeat (2) @(posedge clk);
        if (record_count - at_stop > 1) begin
            $display("%s: %0d frames came after record_stop, at most one allowed",
                     test_name, record_count - at_stop);
            local_errors++;
        end
        if (zcheck_count != zbase) begin
            $display("%s: a zcheck result appeared during a record session", test_name);
            local_errors++;
        end
    endtask

    task automatic run_sweep(input bit stray_start);
        int zbase;
        int rbase;
        int dbase;
        zbase = zcheck_count;
        rbase = record_count;
        dbase = zcheck_done_count;
        zcheck_start <= 1'b1;
        @(posedge clk);
        zcheck_start <= 1'b0;
        wait_busy(1'b1, 2);
        wait_zchecks(zbase + 3, 600);
        if (stray_start) begin
            record_start <= 1'b1;
            @(posedge clk);
            record_start <= 1'b0;
        end
        wait_zchecks(zbase + `ACQ_RHD_CHANNELS + `ACQ_RHS_CHANNELS, 2000);
        wait_busy(1'b0, 300);
        repeat (2) @(posedge clk);
        if (zcheck_count - zbase != `ACQ_RHD_CHANNELS + `ACQ_RHS_CHANNELS) begin
            $display("error %s: zcheck results expected %0d actual %0d", test_name,
                     `ACQ_RHD_CHANNELS + `ACQ_RHS_CHANNELS, zcheck_count - zbase);
            local_errors++;
        end
        if (zcheck_done_count - dbase != 1) begin
            $display("error %s: zcheck_done pulses expected 1 actual %0d",
                     test_name, zcheck_done_count - dbase);
            local_errors++;
        end
        if (record_count != rbase) begin
            $display("%s: a record frame appeared during a zcheck sweep", test_name);
            local_errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        config_done_reset_flag = 1'b1;
        record_start = 1'b0;
        record_stop = 1'b0;
        zcheck_start = 1'b0;
        seed = 25;
        local_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_name = "none";
        repeat (2) @(posedge clk);
        config_done_reset_flag <= 1'b0;
        @(posedge clk);

        begin_test("after_reset");
        repeat (10) begin
            @(posedge clk);
            if ({busy, zcheck_done, data_out_record_valid, data_out_zcheck_valid} !== 4'b0) begin
                $display("error %s: outputs expected 0000 actual %b%b%b%b", test_name,
                         busy, zcheck_done, data_out_record_valid, data_out_zcheck_valid);
                local_errors++;
            end
        end
        end_test();

        begin_test("record_session");
        frames = 1 + ($unsigned($random(seed)) % 4);
        run_record(frames, 1'b0);
        end_test();

        begin_test("zcheck_sweep");
        run_sweep(1'b0);
        end_test();

        // models carry on from where the sweep left them
        begin_test("continuity");
        frames = 1 + ($unsigned($random(seed)) % 4);
        run_record(frames, 1'b0);
        end_test();

        begin_test("start_ignored");
        frames = 1 + ($unsigned($random(seed)) % 4);
        run_record(frames, 1'b1);
        run_sweep(1'b1);
        end_test();

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && checker_errors + local_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hw
hw/acq_pkg.sv
hw/zcheck_channel_counter.sv
hw/chip_engine.sv
hw/loopback_source.sv
hw/acq_sequencer.sv
hw/acq_top.sv
testbench/acq_checker.sv
testbench/tb_acq_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_acq_top -f filelist.f

output=$(./obj_dir/Vtb_acq_top)
echo "$output"

if echo "$output" | grep -q "all tests passed"; then
    exit 0
else
    exit 1
fi
